// ==== common/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

   // Bus widths
   localparam int DW = 32;
   localparam int AW = 32;
   // One select bit per byte lane
   localparam int SW = DW / 8;

   // ------------------------------
   // Master to slave
   // ------------------------------
   typedef struct packed {
      logic [AW-1:0] adr;
      logic [DW-1:0] dat;
      logic [SW-1:0] sel;
      logic          we;
      logic          stb;
      logic          cyc;
   } wb_req_t;

   // ------------------------------
   // Slave to master
   // ------------------------------
   typedef struct packed {
      logic [DW-1:0] dat;
      logic          ack;
      logic          err;
      logic          rty;
   } wb_rsp_t;

endpackage

`default_nettype wire

// ==== common/mig_pkg.sv ====
`default_nettype none

package mig_pkg;

   // Native port field widths
   localparam int PORT_DW = 32;
   localparam int PORT_MW = PORT_DW / 8;
   localparam int BADDR_W = 30;
   localparam int BL_W    = 6;
   localparam int INSTR_W = 3;

   // Instruction codes
   localparam logic [INSTR_W-1:0] INSTR_WR = 3'd0;
   localparam logic [INSTR_W-1:0] INSTR_RD = 3'd1;

   // ------------------------------
   // Command FIFO entry
   // ------------------------------
   typedef struct packed {
      logic [INSTR_W-1:0] instr;
      // Burst length minus one
      logic [BL_W-1:0]    bl;
      logic [BADDR_W-1:0] byte_addr;
   } mig_cmd_t;

   // Write FIFO entry, mask bit high keeps the byte
   typedef struct packed {
      logic [PORT_MW-1:0] mask;
      logic [PORT_DW-1:0] data;
   } mig_wr_beat_t;

   // ------------------------------
   // Port status flags
   // ------------------------------
   typedef struct packed {
      logic cmd_full;
      logic cmd_empty;
      logic wr_full;
      logic wr_empty;
      logic rd_full;
      logic rd_empty;
      logic wr_underrun;
      logic rd_overflow;
      logic wr_error;
      logic rd_error;
   } mig_port_stat_t;

endpackage

`default_nettype wire

// ==== mig_port/mig_port_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module mig_port_fifo #(
   parameter int W  = 32,
   parameter int AW = 2
) (
   input  logic         wb_clk_i,
   input  logic         rst,
   input  logic         push_i,
   input  logic [W-1:0] push_data_i,
   input  logic         pop_i,
   output logic [W-1:0] head_o,
   output logic         full_o,
   output logic         empty_o,
   output logic         overflow_o,
   output logic         underrun_o
);

   localparam int DEPTH = 1 << AW;

   logic [W-1:0]  mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   fill;
   logic          do_push;
   logic          do_pop;

   assign full_o  = (fill == (AW+1)'(DEPTH));
   assign empty_o = (fill == '0);

   // Requests against a full or empty buffer are dropped
   assign do_push = push_i & ~full_o;
   assign do_pop  = pop_i & ~empty_o;

   assign head_o = mem[rd_ptr];

   // Storage
   always_ff @(posedge wb_clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   // Pointers, fill level and sticky error flags
   always_ff @(posedge wb_clk_i) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fill       <= '0;
         overflow_o <= 1'b0;
         underrun_o <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
         if (push_i && full_o) begin
            overflow_o <= 1'b1;
         end
         if (pop_i && empty_o) begin
            underrun_o <= 1'b1;
         end
      end
   end

   // Pointer distance matches the fill level
   assert property (@(posedge wb_clk_i) disable iff (rst)
      AW'(wr_ptr - rd_ptr) == fill[AW-1:0]);

endmodule

`default_nettype wire

// ==== mig_port/mig_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module mig_port #(
   parameter int FIFO_AW = 2
) (
   input  logic                    wb_clk_i,
   input  logic                    rst,
   // Bridge side
   input  logic                    cmd_en_i,
   input  mig_pkg::mig_cmd_t       cmd_i,
   input  logic                    wr_en_i,
   input  mig_pkg::mig_wr_beat_t   wr_beat_i,
   input  logic                    rd_en_i,
   // Back end side
   input  logic                    cmd_pop_i,
   input  logic                    wr_pop_i,
   input  logic                    rd_push_i,
   input  logic [31:0]             rd_push_data_i,
   output mig_pkg::mig_cmd_t       cmd_head_o,
   output mig_pkg::mig_wr_beat_t   wr_head_o,
   output logic [31:0]             rd_data_o,
   output mig_pkg::mig_port_stat_t stat_o
);

   logic cmd_full;
   logic cmd_empty;
   logic wr_full;
   logic wr_empty;
   logic wr_underrun;
   logic rd_full;
   logic rd_empty;
   logic rd_overflow;
   logic rd_underrun;
   logic wr_error_q;

   // ------------------------------
   // Command FIFO
   // ------------------------------
   mig_port_fifo #(
      .W  ($bits(mig_pkg::mig_cmd_t)),
      .AW (FIFO_AW)
   ) u_cmd_fifo (
      .wb_clk_i    (wb_clk_i),
      .rst         (rst),
      .push_i      (cmd_en_i),
      .push_data_i (cmd_i),
      .pop_i       (cmd_pop_i),
      .head_o      (cmd_head_o),
      .full_o      (cmd_full),
      .empty_o     (cmd_empty),
      .overflow_o  (),
      .underrun_o  ()
   );

   // Write data FIFO
   mig_port_fifo #(
      .W  ($bits(mig_pkg::mig_wr_beat_t)),
      .AW (FIFO_AW)
   ) u_wr_fifo (
      .wb_clk_i    (wb_clk_i),
      .rst         (rst),
      .push_i      (wr_en_i),
      .push_data_i (wr_beat_i),
      .pop_i       (wr_pop_i),
      .head_o      (wr_head_o),
      .full_o      (wr_full),
      .empty_o     (wr_empty),
      .overflow_o  (),
      .underrun_o  (wr_underrun)
   );

   // Read data FIFO, filled by the back end
   mig_port_fifo #(
      .W  (mig_pkg::PORT_DW),
      .AW (FIFO_AW)
   ) u_rd_fifo (
      .wb_clk_i    (wb_clk_i),
      .rst         (rst),
      .push_i      (rd_push_i),
      .push_data_i (rd_push_data_i),
      .pop_i       (rd_en_i),
      .head_o      (rd_data_o),
      .full_o      (rd_full),
      .empty_o     (rd_empty),
      .overflow_o  (rd_overflow),
      .underrun_o  (rd_underrun)
   );

   // Write command at the head without its beat
   always_ff @(posedge wb_clk_i) begin
      if (rst) begin
         wr_error_q <= 1'b0;
      end else if (!cmd_empty && cmd_head_o.instr == mig_pkg::INSTR_WR && wr_empty) begin
         wr_error_q <= 1'b1;
      end
   end

   // ------------------------------
   // Gathered status
   // ------------------------------
   assign stat_o = '{
      cmd_full:    cmd_full,
      cmd_empty:   cmd_empty,
      wr_full:     wr_full,
      wr_empty:    wr_empty,
      rd_full:     rd_full,
      rd_empty:    rd_empty,
      wr_underrun: wr_underrun,
      rd_overflow: rd_overflow,
      wr_error:    wr_error_q,
      rd_error:    rd_underrun
   };

endmodule

`default_nettype wire

// ==== hw/sram_backend.sv ====
`timescale 1ns/10ps
`default_nettype none

module sram_backend #(
   parameter int MEM_AW  = 8,
   parameter int SVC_GAP = 3
) (
   input  logic                  wb_clk_i,
   input  logic                  rst,
   input  mig_pkg::mig_cmd_t     cmd_head_i,
   input  logic                  cmd_empty_i,
   input  mig_pkg::mig_wr_beat_t wr_head_i,
   input  logic                  rd_full_i,
   output logic                  cmd_pop_o,
   output logic                  wr_pop_o,
   output logic                  rd_push_o,
   output logic [31:0]           rd_push_data_o
);

   localparam int DEPTH = 1 << MEM_AW;
   localparam int GAP_W = (SVC_GAP < 1) ? 1 : $clog2(SVC_GAP + 1);

   logic [mig_pkg::PORT_DW-1:0] mem [DEPTH];
   logic [MEM_AW-1:0]           idx;
   logic [GAP_W-1:0]            gap_q;
   logic                        is_rd;
   logic                        start;
   logic                        rd_pend_q;

   // Low word address bits only so upper bits alias
   assign idx   = cmd_head_i.byte_addr[MEM_AW+1:2];
   assign is_rd = (cmd_head_i.instr == mig_pkg::INSTR_RD);

   // Start needs a command, an expired gap and room for a read result
   assign start = ~cmd_empty_i & (gap_q == '0) & (~is_rd | ~rd_full_i);

   assign cmd_pop_o = start;
   // Write beat leaves together with its command
   assign wr_pop_o  = start & ~is_rd;

   // ------------------------------
   // Word array
   // ------------------------------
   always_ff @(posedge wb_clk_i) begin
      if (rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (start && !is_rd) begin
         // Byte lanes with mask low get written
         for (int b = 0; b < mig_pkg::PORT_MW; b++) begin
            if (!wr_head_i.mask[b]) begin
               mem[idx][8*b +: 8] <= wr_head_i.data[8*b +: 8];
            end
         end
      end
   end

   // Read word registered and pushed one cycle later
   always_ff @(posedge wb_clk_i) begin
      if (start && is_rd) begin
         rd_push_data_o <= mem[idx];
      end
   end

   // ------------------------------
   // Control
   // ------------------------------
   always_ff @(posedge wb_clk_i) begin
      if (rst) begin
         gap_q     <= '0;
         rd_pend_q <= 1'b0;
      end else begin
         rd_pend_q <= start & is_rd;
         if (start) begin
            gap_q <= GAP_W'(SVC_GAP);
         end else if (gap_q != '0) begin
            gap_q <= gap_q - 1'b1;
         end
      end
   end

   assign rd_push_o = rd_pend_q;

   // Delayed read result still finds room in the read FIFO
   assert property (@(posedge wb_clk_i) disable iff (rst)
      rd_push_o |-> !rd_full_i);

endmodule

`default_nettype wire

// ==== hw/wb_mig_if.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_mig_if (
   input  logic                   wb_clk_i,
   input  logic                   rst,
   input  wb_pkg::wb_req_t        wb_req_i,
   input  logic [31:0]            rd_data_i,
   input  mig_pkg::mig_port_stat_t port_stat_i,
   output logic [31:0]            wb_dat_o,
   output logic                   wb_ack_o,
   output logic                   wb_err_o,
   output logic                   cmd_en_o,
   output mig_pkg::mig_cmd_t      cmd_o,
   output logic                   wr_en_o,
   output mig_pkg::mig_wr_beat_t  wr_beat_o,
   output logic                   rd_en_o
);

   // Word address bits carried in the byte address
   localparam int WADR_W = mig_pkg::BADDR_W - 2;

   typedef enum logic [2:0] {
      IDLE,
      READ,
      READ_WAIT,
      READ_ACK,
      WRITE,
      WRITE_CMD
   } state_t;

   state_t              state_q;
   state_t              state_d;
   logic [WADR_W-1:0]   word_adr_q;
   logic                wb_active;
   logic                cmd_room;
   logic                accept;

   assign wb_active = wb_req_i.cyc & wb_req_i.stb;

   // WRITE_CMD pushes a command in this very cycle and cmd_full does not
   // show it yet, so only an empty command FIFO is safe there
   assign cmd_room = (state_q == WRITE_CMD) ? port_stat_i.cmd_empty
                                            : ~port_stat_i.cmd_full;

   // ------------------------------
   // State register
   // ------------------------------
   always_ff @(posedge wb_clk_i) begin
      if (rst) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE, WRITE_CMD: begin
            state_d = IDLE;
            if (wb_active && cmd_room) begin
               if (!wb_req_i.we) begin
                  state_d = READ;
               end else if (!port_stat_i.wr_full) begin
                  state_d = WRITE;
               end
            end
         end
         // Command goes out, then wait for the word
         READ: begin
            state_d = READ_WAIT;
         end
         READ_WAIT: begin
            if (!port_stat_i.rd_empty) begin
               state_d = READ_ACK;
            end
         end
         READ_ACK: begin
            state_d = IDLE;
         end
         // Beat pushed and acked, command follows
         WRITE: begin
            state_d = WRITE_CMD;
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   // New transfer taken on
   assign accept = (state_d == READ) || (state_d == WRITE);

   // Word address held for the later command push
   always_ff @(posedge wb_clk_i) begin
      if (accept) begin
         word_adr_q <= wb_req_i.adr[WADR_W+1:2];
      end
   end

   // ------------------------------
   // Outputs decoded from state
   // ------------------------------
   assign cmd_en_o = (state_q == READ) || (state_q == WRITE_CMD);
   assign wr_en_o  = (state_q == WRITE);
   assign rd_en_o  = (state_q == READ_ACK);
   assign wb_ack_o = (state_q == WRITE) || (state_q == READ_ACK);

   // Single word, so burst length field stays zero
   assign cmd_o = '{
      instr:     (state_q == READ) ? mig_pkg::INSTR_RD : mig_pkg::INSTR_WR,
      bl:        '0,
      byte_addr: {word_adr_q, 2'b00}
   };

   // Port mask is the inverse of the byte selects
   assign wr_beat_o = '{
      mask: ~wb_req_i.sel,
      data: wb_req_i.dat
   };

   assign wb_dat_o = rd_data_i;
   assign wb_err_o = port_stat_i.wr_underrun | port_stat_i.rd_overflow |
                     port_stat_i.wr_error | port_stat_i.rd_error;

   // No command is pushed into a full FIFO
   assert property (@(posedge wb_clk_i) disable iff (rst)
      cmd_en_o |-> !port_stat_i.cmd_full);

endmodule

`default_nettype wire

// ==== hw/wb_mig_sys.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_mig_sys #(
   parameter int MEM_AW  = 8,
   parameter int FIFO_AW = 2,
   parameter int SVC_GAP = 3
) (
   input  logic            wb_clk_i,
   input  logic            rst,
   input  wb_pkg::wb_req_t wb_req_i,
   output wb_pkg::wb_rsp_t wb_rsp_o
);

   // Bridge to port
   logic                    cmd_en;
   mig_pkg::mig_cmd_t       cmd;
   logic                    wr_en;
   mig_pkg::mig_wr_beat_t   wr_beat;
   logic                    rd_en;
   logic [31:0]             rd_data;
   mig_pkg::mig_port_stat_t port_stat;
   // Back end to port
   logic                    cmd_pop;
   logic                    wr_pop;
   logic                    rd_push;
   logic [31:0]             rd_push_data;
   mig_pkg::mig_cmd_t       cmd_head;
   mig_pkg::mig_wr_beat_t   wr_head;
   // Response pieces
   logic [wb_pkg::DW-1:0]   rsp_dat;
   logic                    rsp_ack;
   logic                    rsp_err;

   // ------------------------------
   // Producer
   // ------------------------------
   wb_mig_if u_wb_mig_if (
      .wb_clk_i    (wb_clk_i),
      .rst         (rst),
      .wb_req_i    (wb_req_i),
      .rd_data_i   (rd_data),
      .port_stat_i (port_stat),
      .wb_dat_o    (rsp_dat),
      .wb_ack_o    (rsp_ack),
      .wb_err_o    (rsp_err),
      .cmd_en_o    (cmd_en),
      .cmd_o       (cmd),
      .wr_en_o     (wr_en),
      .wr_beat_o   (wr_beat),
      .rd_en_o     (rd_en)
   );

   // Port FIFOs
   mig_port #(
      .FIFO_AW (FIFO_AW)
   ) u_mig_port (
      .wb_clk_i       (wb_clk_i),
      .rst            (rst),
      .cmd_en_i       (cmd_en),
      .cmd_i          (cmd),
      .wr_en_i        (wr_en),
      .wr_beat_i      (wr_beat),
      .rd_en_i        (rd_en),
      .cmd_pop_i      (cmd_pop),
      .wr_pop_i       (wr_pop),
      .rd_push_i      (rd_push),
      .rd_push_data_i (rd_push_data),
      .cmd_head_o     (cmd_head),
      .wr_head_o      (wr_head),
      .rd_data_o      (rd_data),
      .stat_o         (port_stat)
   );

   // Consumer
   sram_backend #(
      .MEM_AW  (MEM_AW),
      .SVC_GAP (SVC_GAP)
   ) u_sram_backend (
      .wb_clk_i       (wb_clk_i),
      .rst            (rst),
      .cmd_head_i     (cmd_head),
      .cmd_empty_i    (port_stat.cmd_empty),
      .wr_head_i      (wr_head),
      .rd_full_i      (port_stat.rd_full),
      .cmd_pop_o      (cmd_pop),
      .wr_pop_o       (wr_pop),
      .rd_push_o      (rd_push),
      .rd_push_data_o (rd_push_data)
   );

   // No retry
   assign wb_rsp_o = '{dat: rsp_dat, ack: rsp_ack, err: rsp_err, rty: 1'b0};

endmodule

`default_nettype wire

// ==== sim/tb_wb_mig_sys.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_wb_mig_sys;

   localparam int MEM_AW     = 8;
   localparam int FIFO_AW    = 2;
   localparam int SVC_GAP    = 3;
   localparam int CLK_PERIOD = 20;

   // Test sizes
   localparam int T1_N    = 4;
   localparam int SEL_N   = 8;
   localparam int ALIAS_N = 3;
   localparam int BP_N    = 16;
   localparam int RAND_N  = 200;
   localparam int N_OPS   = 2*T1_N + 1 + 2*SEL_N + ALIAS_N + 4 + 2*BP_N + RAND_N;
   localparam longint WD_NS = longint'(N_OPS) * (SVC_GAP + 10) * CLK_PERIOD
                              + 8 * CLK_PERIOD + 2000;

   // Partial byte select patterns
   localparam logic [3:0] SEL_PAT [SEL_N] = '{4'h1, 4'h2, 4'h4, 4'h8,
                                             4'h3, 4'hC, 4'h5, 4'hE};

   logic            wb_clk_i = 1'b0;
   logic            rst;
   wb_pkg::wb_req_t wb_req;
   wb_pkg::wb_rsp_t wb_rsp;

   // Reference memory with the same aliasing as the SRAM
   logic [31:0] ref_mem [1 << MEM_AW];
   logic [31:0] exp_q [$];
   string       cur_test;
   int          data_errs;
   int          flag_errs;
   int          other_errs;
   int          ack_count;
   int          ops_done;

   wb_mig_sys #(
      .MEM_AW  (MEM_AW),
      .FIFO_AW (FIFO_AW),
      .SVC_GAP (SVC_GAP)
   ) u_wb_mig_sys (
      .wb_clk_i (wb_clk_i),
      .rst      (rst),
      .wb_req_i (wb_req),
      .wb_rsp_o (wb_rsp)
   );

   always #(CLK_PERIOD/2) wb_clk_i = ~wb_clk_i;

   // ------------------------------
   // Reference model
   // ------------------------------
   function automatic logic [MEM_AW-1:0] ref_index(input logic [31:0] adr);
      // Word address where upper bits alias
      return adr[MEM_AW+1:2];
   endfunction

   function automatic logic [31:0] ref_read(input logic [31:0] adr);
      return ref_mem[ref_index(adr)];
   endfunction

   task automatic ref_write(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
      logic [31:0] word;
      word = ref_mem[ref_index(adr)];
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            word[8*b +: 8] = dat[8*b +: 8];
         end
      end
      ref_mem[ref_index(adr)] = word;
   endtask

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic check_data(input string name, input logic [wb_pkg::DW-1:0] exp,
                             input logic [wb_pkg::DW-1:0] act);
      if (act !== exp) begin
         $display("ERROR %s: read data expected %08h actual %08h", name, exp, act);
         data_errs++;
      end
   endtask

   task automatic check_rsp_flags(input string name, input wb_pkg::wb_rsp_t exp,
                                  input wb_pkg::wb_rsp_t act);
      if (act.err !== exp.err || act.rty !== exp.rty) begin
         $display("ERROR %s: err/rty expected %b/%b actual %b/%b",
                  name, exp.err, exp.rty, act.err, act.rty);
         flag_errs++;
      end
   endtask

   // ------------------------------
   // Wishbone master tasks
   // ------------------------------
   // Called 2 ns after a rising edge and returns 2 ns after the ack edge
   task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel);
      ref_write(adr, dat, sel);
      wb_req = '{adr: adr, dat: dat, sel: sel, we: 1'b1, stb: 1'b1, cyc: 1'b1};
      do @(posedge wb_clk_i); while (wb_rsp.ack !== 1'b1);
      #2;
      wb_req.stb = 1'b0;
      wb_req.cyc = 1'b0;
      ops_done++;
   endtask

   task automatic wb_read(input logic [31:0] adr);
      // Expected word queued for the compare process
      exp_q.push_back(ref_read(adr));
      wb_req = '{adr: adr, dat: '0, sel: 4'hF, we: 1'b0, stb: 1'b1, cyc: 1'b1};
      do @(posedge wb_clk_i); while (wb_rsp.ack !== 1'b1);
      #2;
      wb_req.stb = 1'b0;
      wb_req.cyc = 1'b0;
      ops_done++;
   endtask

   // Response checker on every acked cycle
   always @(posedge wb_clk_i) begin
      if (!rst && wb_rsp.ack === 1'b1) begin
         ack_count++;
         check_rsp_flags(cur_test, '{dat: '0, ack: 1'b1, err: 1'b0, rty: 1'b0}, wb_rsp);
         if (!wb_req.we) begin
            if (exp_q.size() == 0) begin
               $display("Read acknowledge without a pending read in %s", cur_test);
               other_errs++;
            end else begin
               check_data(cur_test, exp_q.pop_front(), wb_rsp.dat);
            end
         end
      end
   end

   // Watchdog
   initial begin
      #(WD_NS);
      $display("Timeout: the run did not finish within %0d ns", WD_NS);
      $display("tests failed");
      $finish;
   end

   // ------------------------------
   // Stimulus
   // ------------------------------
   initial begin
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      void'($urandom(44157));
      wb_req     = '0;
      rst        = 1'b1;
      cur_test   = "reset";
      data_errs  = 0;
      flag_errs  = 0;
      other_errs = 0;
      ack_count  = 0;
      ops_done   = 0;
      for (int i = 0; i < (1 << MEM_AW); i++) begin
         ref_mem[i] = '0;
      end
      repeat (8) @(posedge wb_clk_i);
      #2;
      rst = 1'b0;

      // Full word write then read back
      cur_test = "write_read";
      for (int i = 0; i < T1_N; i++) begin
         adr = 32'h40 + 4*i;
         wb_write(adr, $urandom, 4'hF);
         wb_read(adr);
      end

      // Partial selects over a known base word
      cur_test = "byte_mask";
      adr = 32'h80;
      wb_write(adr, 32'h1122_3344, 4'hF);
      for (int i = 0; i < SEL_N; i++) begin
         wb_write(adr, $urandom, SEL_PAT[i]);
         wb_read(adr);
      end

      // Upper address bits ignored by the array
      cur_test = "alias";
      adr = 32'h0000_00C4;
      wb_write(adr, 32'hA5A5_5A5A, 4'hF);
      for (int k = 1; k <= ALIAS_N; k++) begin
         wb_read(adr | (k << (MEM_AW + 2)));
      end
      wb_write(adr | 32'h8000_0000, 32'h0F0F_F0F0, 4'hF);
      wb_read(adr);
      wb_read(adr | (1 << (MEM_AW + 2)));

      // Back to back writes outrun the back end
      cur_test = "back_pressure";
      for (int i = 0; i < BP_N; i++) begin
         wb_write(32'h100 + 4*i, $urandom, 4'hF);
      end
      for (int i = 0; i < BP_N; i++) begin
         wb_read(32'h100 + 4*i);
      end

      // Random mix over a small window plus aliased upper bits
      cur_test = "random";
      for (int i = 0; i < RAND_N; i++) begin
         adr = {2'($urandom_range(3, 0)), 20'h0, 6'($urandom_range(63, 0)), 4'h0};
         adr[3:2] = 2'($urandom_range(3, 0));
         dat = $urandom;
         sel = 4'($urandom_range(15, 0));
         if ($urandom_range(1, 0) == 1) begin
            wb_write(adr, dat, sel);
         end else begin
            wb_read(adr);
         end
      end

      repeat (4) @(posedge wb_clk_i);
      cur_test = "final";
      check_rsp_flags(cur_test, '{dat: '0, ack: 1'b0, err: 1'b0, rty: 1'b0}, wb_rsp);
      // One ack per transfer
      if (ack_count != ops_done) begin
         $display("Acknowledge count %0d does not match %0d transfers", ack_count, ops_done);
         other_errs++;
      end
      if (exp_q.size() != 0) begin
         $display("%0d reads never returned data", exp_q.size());
         other_errs++;
      end
      $display("Errors: %0d data, %0d flags, %0d other", data_errs, flag_errs, other_errs);
      if (data_errs == 0 && flag_errs == 0 && other_errs == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
common/wb_pkg.sv
common/mig_pkg.sv
mig_port/mig_port_fifo.sv
mig_port/mig_port.sv
hw/sram_backend.sv
hw/wb_mig_if.sv
hw/wb_mig_sys.sv
sim/tb_wb_mig_sys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f src.f --top-module tb_wb_mig_sys \
   -Mdir obj_dir -o tb_wb_mig_sys > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_wb_mig_sys > sim.log 2>&1
cat sim.log
grep -qx "all tests passed" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
